//--- bench/tb_video.sv
//********************
// testbench top with clock, reset, apb tasks, memory model, test table and watchdog
//********************
`timescale 1ns/100ps
`include "video_settings.svh"

module tb_video;
  import video_pkg::*;

  localparam int NROWS    = 6;
  localparam int CLK_NS   = 40;
  localparam int FRAME_NS = `HI_HTOT * `HI_VTOT * CLK_NS;  // longer of the two formats
  localparam int WDOG_NS  = NROWS * 2 * FRAME_NS + NROWS * FRAME_NS + 4000;

  logic        clk_128;
  logic        arst_n;
  logic        psel, penable, pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        pready;
  logic        mem_read;
  vaddr_t      mem_addr;
  vword_t      mem_data = '0;
  logic        mem_valid = 1'b0;
  logic        de, hs, vs;
  rgb_t        rgb;

  logic         check_en;
  logic [127:0] test_name;
  int           exp_gap;
  int           pix_errs, sync_errs, apb_errs, bus_errs, pix_checked;

  // memory model state
  integer seed = 42;
  logic   mem_busy = 1'b0;
  int     lat_cnt = 0;
  vaddr_t rd_addr = '0;

  // one test row per configuration
  logic [127:0] row_name [NROWS];
  logic [31:0]  row_ctrl [NROWS];
  logic [15:0]  row_lo   [NROWS];
  logic [15:0]  row_hi   [NROWS];
  logic [2:0]   row_adj  [NROWS];
  logic [11:0]  row_pal  [NROWS][4];
  int           row_gap  [NROWS];  // de fall to hs rise

  video_top i_dut (
    .clk_128, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .mem_read, .mem_addr, .mem_data, .mem_valid, .de, .hs, .vs, .rgb
  );

  video_checker i_chk (
    .clk_128, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .mem_read, .mem_valid, .de, .hs, .vs, .rgb,
    .check_en, .test_name, .exp_hs_gap(exp_gap),
    .pix_errs, .sync_errs, .apb_errs, .bus_errs, .pix_checked
  );

  initial begin
    clk_128 = 1'b0;
    forever #(CLK_NS / 2) clk_128 = ~clk_128;
  end

  initial begin
    #(WDOG_NS);
    $display("watchdog expired before all test rows completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic vword_t mem_hash(input vaddr_t a);
    vword_t p;
    p = a * 16'h9E37;
    mem_hash = p ^ {a[7:0], a[15:8]} ^ 16'h5AC3;
  endfunction

  // video memory with 1 to 3 cycles of latency
  always @(negedge clk_128) begin
    mem_valid <= 1'b0;
    if (!arst_n) begin
      mem_busy <= 1'b0;
    end else begin
      if (mem_busy) begin
        if (lat_cnt == 1) begin
          mem_valid <= 1'b1;
          mem_data  <= mem_hash(rd_addr);
          mem_busy  <= 1'b0;
        end else begin
          lat_cnt <= lat_cnt - 1;
        end
      end
      if (mem_read) begin
        mem_busy <= 1'b1;
        rd_addr  <= mem_addr;
        lat_cnt  <= 1 + ({$random(seed)} % 3);
      end
    end
  end

  task automatic fill_table();
    row_name = '{"lores_basic", "lores_scan_a3", "hires_plain",
                 "hires_invert", "hires_scan_pol", "lores_all_pol"};
    row_ctrl = '{32'h00, 32'h0A, 32'h01, 32'h15, 32'h0F, 32'h0E};
    row_adj  = '{3'd0, 3'd3, 3'd7, 3'd0, 3'd3, 3'd7};
    row_gap  = '{5, 8, 12, 5, 8, 12};  // hs_start + adjust + 1
    // row 3 hi base and row 5 lo base wrap past the top
    row_lo   = '{16'h0100, 16'h1234, 16'h0100, 16'h0100, 16'h0300, 16'hFFFA};
    row_hi   = '{16'h0800, 16'h0800, 16'h2000, 16'hFFF8, 16'h4321, 16'h0800};
    for (int r = 0; r < NROWS; r++) begin
      row_pal[r][0] = (r % 2) ? 12'h888 : 12'h000;
      row_pal[r][1] = 12'hF00 ^ 12'(r * 12'h111);
      row_pal[r][2] = 12'h0F0 ^ 12'(r * 12'h025);
      row_pal[r][3] = 12'hA5F;
    end
  endtask

  task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
    @(negedge clk_128);
    psel    = 1'b1;
    pwrite  = 1'b1;
    penable = 1'b0;
    paddr   = a;
    pwdata  = d;
    @(negedge clk_128);
    penable = 1'b1;  // access phase
    @(negedge clk_128);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] a);
    @(negedge clk_128);
    psel    = 1'b1;
    pwrite  = 1'b0;
    penable = 1'b0;
    paddr   = a;
    @(negedge clk_128);
    penable = 1'b1;  // checker compares prdata here
    @(negedge clk_128);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // returns at the falling edge after vsync becomes active
  task automatic wait_frame_start(input logic pol);
    logic prev, cur, rise;
    @(negedge clk_128);
    prev = vs ^ pol;
    do begin
      @(negedge clk_128);
      cur  = vs ^ pol;
      rise = cur && !prev;
      prev = cur;
    end while (!rise);
  endtask

  initial begin
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    check_en  = 1'b0;
    test_name = "reset";
    exp_gap   = 0;
    fill_table();
    arst_n = 1'b0;
    repeat (3) @(posedge clk_128);
    @(negedge clk_128);
    arst_n = 1'b1;

    for (int r = 0; r < NROWS; r++) begin
      test_name = row_name[r];
      exp_gap   = row_gap[r];
      apb_write(`REG_CTRL, row_ctrl[r]);
      apb_write(`REG_LO_BASE, {16'h0, row_lo[r]});
      apb_write(`REG_HI_BASE, {16'hABCD, row_hi[r]});  // upper half dropped
      apb_write(`REG_ADJ, {29'h0, row_adj[r]});
      apb_write(`REG_PAL0, {20'h0, row_pal[r][0]});
      apb_write(`REG_PAL1, {20'h0, row_pal[r][1]});
      apb_write(`REG_PAL2, {20'h0, row_pal[r][2]});
      apb_write(`REG_PAL3, {20'h0, row_pal[r][3]});
      apb_write(8'h24, 32'hFFFF_FFFF);  // unmapped
      for (int i = 0; i < 8; i++) apb_read(8'(i * 4));
      apb_read(8'h20);
      apb_read(8'h24);
      apb_read(8'h06);
      // first frame after the change is skipped
      wait_frame_start(row_ctrl[r][2]);
      check_en = 1'b1;
      wait_frame_start(row_ctrl[r][2]);
      @(negedge clk_128);
      check_en = 1'b0;
    end

    repeat (2) @(negedge clk_128);
    $display("errors: pixel %0d, sync %0d, apb %0d, bus %0d, pixels checked %0d",
             pix_errs, sync_errs, apb_errs, bus_errs, pix_checked);
    if (pix_errs + sync_errs + apb_errs + bus_errs == 0 && pix_checked > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      if (pix_checked == 0) $display("no pixels were checked");
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- bench/video_checker.sv
//********************
// apb shadow registers with pixel, sync and memory port checks
//********************
`timescale 1ns/100ps
`include "video_settings.svh"

module video_checker (
  input  logic            clk_128,
  input  logic            arst_n,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [7:0]      paddr,
  input  logic [31:0]     pwdata,
  input  logic [31:0]     prdata,
  input  logic            pready,
  input  logic            mem_read,
  input  logic            mem_valid,
  input  logic            de,
  input  logic            hs,
  input  logic            vs,
  input  video_pkg::rgb_t rgb,
  input  logic            check_en,
  input  logic [127:0]    test_name,
  input  int              exp_hs_gap,
  output int              pix_errs,
  output int              sync_errs,
  output int              apb_errs,
  output int              bus_errs,
  output int              pix_checked
);
  import video_pkg::*;

  logic [31:0] shadow [8];  // ctrl, lo, hi, adj, pal0..3
  logic [31:0] exp_rd;
  rgb_t        exp_px;
  logic        map_hit;
  logic [2:0]  map_idx;
  logic        cfg_mode, cfg_hs_pol, cfg_vs_pol, cfg_scan, cfg_inv;
  logic        hs_act, vs_act;
  logic        de_q, hs_q, vs_q;
  logic        in_frame;    // frame started with checking on
  logic        gap_run;     // counting from de fall to hs rise
  logic        rd_pending;
  int          line_cnt, pix_cnt, gap_cnt;
  int          vact, hact;

  assign map_hit    = (paddr[7:5] == 3'd0) && (paddr[1:0] == 2'd0);
  assign map_idx    = paddr[4:2];
  assign cfg_mode   = shadow[0][0];
  assign cfg_hs_pol = shadow[0][1];
  assign cfg_vs_pol = shadow[0][2];
  assign cfg_scan   = shadow[0][3];
  assign cfg_inv    = shadow[0][4];
  assign hs_act     = hs ^ cfg_hs_pol;  // polarity 0 is active high
  assign vs_act     = vs ^ cfg_vs_pol;
  assign vact       = cfg_mode ? `HI_VACT : `LO_VACT;
  assign hact       = cfg_mode ? `HI_HACT : `LO_HACT;

  function automatic logic [31:0] reg_mask(input logic [2:0] idx);
    case (idx)
      3'd0:       reg_mask = 32'h0000_001F;  // five ctrl bits
      3'd1, 3'd2: reg_mask = 32'h0000_FFFF;
      3'd3:       reg_mask = 32'h0000_0007;
      default:    reg_mask = 32'h0000_0FFF;  // palette colour
    endcase
  endfunction

  // same content the memory model serves
  function automatic vword_t mem_hash(input vaddr_t a);
    vword_t p;
    p = a * 16'h9E37;
    mem_hash = p ^ {a[7:0], a[15:8]} ^ 16'h5AC3;
  endfunction

  function automatic rgb_t pixel_expect(input int line, input int pix);
    vaddr_t      base;
    logic [31:0] bits;
    rgb_t        c;
    pal_idx_t    idx;
    base = cfg_mode ? shadow[2][15:0] : shadow[1][15:0];
    bits = {mem_hash(base + vaddr_t'(2 * line)), mem_hash(base + vaddr_t'(2 * line + 1))};
    if (cfg_mode) begin
      bits = bits << pix;
      c    = (bits[31] ^ cfg_inv) ? 12'hFFF : 12'h000;  // mono
    end else begin
      bits = bits << (2 * pix);
      idx  = bits[31:30];
      c    = shadow[4 + idx][11:0];
    end
    if (cfg_scan && line[0])
      c = {c[11:8] >> 1, c[7:4] >> 1, c[3:0] >> 1};  // each channel halved
    pixel_expect = c;
  endfunction

  always @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 8; i++) shadow[i] <= '0;
      de_q        <= 1'b0;
      hs_q        <= 1'b0;
      vs_q        <= 1'b0;
      in_frame    <= 1'b0;
      gap_run     <= 1'b0;
      rd_pending  <= 1'b0;
      line_cnt    <= 0;
      pix_cnt     <= 0;
      gap_cnt     <= 0;
      pix_errs    = 0;
      sync_errs   = 0;
      apb_errs    = 0;
      bus_errs    = 0;
      pix_checked = 0;
    end else begin
      // write lands at the end of the apb access phase
      if (psel && penable && pwrite && map_hit)
        shadow[map_idx] <= pwdata & reg_mask(map_idx);
      if (psel && penable && pready !== 1'b1) begin
        $display("FAILED %0s: apb pready, expected 1, actual %b", test_name, pready);
        apb_errs++;
      end
      if (psel && penable && !pwrite) begin
        exp_rd = map_hit ? shadow[map_idx] : 32'h0;
        if (prdata !== exp_rd) begin
          $display("FAILED %0s: apb read 0x%02h, expected 0x%08h, actual 0x%08h",
                   test_name, paddr, exp_rd, prdata);
          apb_errs++;
        end
      end

      // one read in flight at most
      if (mem_read && rd_pending) begin
        $display("%0s: mem_read pulsed while a read was still pending", test_name);
        bus_errs++;
      end
      if (mem_read) rd_pending <= 1'b1;
      else if (mem_valid) rd_pending <= 1'b0;

      if (de && check_en && in_frame) begin
        exp_px = pixel_expect(line_cnt, pix_cnt);
        if (rgb !== exp_px) begin
          $display("FAILED %0s: pixel line %0d col %0d, expected 0x%03h, actual 0x%03h",
                   test_name, line_cnt, pix_cnt, exp_px, rgb);
          pix_errs++;
        end
        pix_checked++;
      end
      if (de) pix_cnt <= pix_cnt + 1;

      if (!de && de_q) begin  // end of an active line
        if (check_en && in_frame && pix_cnt != hact) begin
          $display("FAILED %0s: pixels per line, expected %0d, actual %0d",
                   test_name, hact, pix_cnt);
          sync_errs++;
        end
        line_cnt <= line_cnt + 1;
        pix_cnt  <= 0;
        gap_run  <= 1'b1;
        gap_cnt  <= 1;
      end else if (gap_run) begin
        if (hs_act && !hs_q) begin
          if (check_en && in_frame && gap_cnt != exp_hs_gap) begin
            $display("FAILED %0s: hsync delay after de, expected %0d, actual %0d",
                     test_name, exp_hs_gap, gap_cnt);
            sync_errs++;
          end
          gap_run <= 1'b0;
        end else begin
          gap_cnt <= gap_cnt + 1;
        end
      end

      // vsync rise opens a new frame
      if (vs_act && !vs_q) begin
        if (check_en && in_frame && line_cnt != vact) begin
          $display("FAILED %0s: active lines per frame, expected %0d, actual %0d",
                   test_name, vact, line_cnt);
          sync_errs++;
        end
        in_frame <= check_en;
        line_cnt <= 0;
      end

      de_q <= de;
      hs_q <= hs_act;
      vs_q <= vs_act;
    end
  end

endmodule

//--- logic/hires_shifter.sv
//********************
// high-res engine, beam counters, line fetch and 1 bpp mono output
//********************
`timescale 1ns/100ps
`include "video_settings.svh"

module hires_shifter (
  input  logic              clk_128,
  input  logic              arst_n,
  input  video_pkg::vaddr_t base,
  input  logic              invert,
  output logic              req,
  output video_pkg::vaddr_t addr,
  input  logic              gnt,
  input  video_pkg::vword_t rdata,
  input  logic              rvalid,
  output logic              de,
  output logic              hs,
  output logic              vs,
  output video_pkg::rgb_t   rgb,
  output logic              line_odd
);
  import video_pkg::*;

  localparam hcount_t HACT   = hcount_t'(`HI_HACT);
  localparam hcount_t HTOT   = hcount_t'(`HI_HTOT);
  localparam vcount_t VACT   = vcount_t'(`HI_VACT);
  localparam vcount_t VTOT   = vcount_t'(`HI_VTOT);
  localparam hcount_t HS_ON  = hcount_t'(`HI_HACT + `HS_START);
  localparam hcount_t HS_OFF = hcount_t'(`HI_HACT + `HS_START + `HS_LEN);
  localparam vcount_t VS_OFF = vcount_t'(`HI_VACT + `VS_LINES);

  hcount_t      hcnt;
  vcount_t      vcnt;
  vcount_t      next_line;
  fetch_state_e fstate;
  logic         word_sel;
  vword_t       line_buf [2];
  logic [31:0]  pix_sr;  // 32 pixels
  logic         line_end, next_active, active;

  assign line_end    = (hcnt == HTOT - 1'b1);
  assign next_line   = (vcnt == VTOT - 1'b1) ? '0 : vcnt + 1'b1;
  assign next_active = (next_line < VACT);
  assign active      = (hcnt < HACT) && (vcnt < VACT);
  assign req         = (fstate == FS_REQ);

  always_ff @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      hcnt <= '0;
      vcnt <= '0;
    end else begin
      hcnt <= line_end ? '0 : hcnt + 1'b1;
      if (line_end) vcnt <= next_line;
    end
  end

  // 16 cycle blank, tighter than low-res
  always_ff @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      fstate   <= FS_IDLE;
      word_sel <= 1'b0;
      addr     <= '0;
    end else begin
      case (fstate)
        FS_IDLE: if (hcnt == HACT && next_active) begin
          addr     <= base + vaddr_t'({next_line, 1'b0});
          word_sel <= 1'b0;
          fstate   <= FS_REQ;
        end
        FS_REQ: if (gnt) fstate <= FS_WAIT;  // only one read outstanding
        FS_WAIT: if (rvalid) begin
          if (word_sel) begin
            fstate <= FS_DONE;
          end else begin
            word_sel <= 1'b1;
            addr     <= addr + 1'b1;
            fstate   <= FS_REQ;
          end
        end
        FS_DONE: if (line_end) fstate <= FS_IDLE;
        default: fstate <= FS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_128) begin
    if (fstate == FS_WAIT && rvalid) line_buf[word_sel] <= rdata;
    if (line_end && next_active) pix_sr <= {line_buf[0], line_buf[1]};
    else if (active) pix_sr <= pix_sr << 1;
  end

  always_ff @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      de       <= 1'b0;
      hs       <= 1'b0;
      vs       <= 1'b0;
      rgb      <= '0;
      line_odd <= 1'b0;
    end else begin
      de       <= active;
      hs       <= (hcnt >= HS_ON) && (hcnt < HS_OFF);
      vs       <= (vcnt >= VACT) && (vcnt < VS_OFF);
      rgb      <= (active && (pix_sr[31] ^ invert)) ? '1 : '0;  // white or black
      line_odd <= vcnt[0];
    end
  end

endmodule

//--- logic/lores_shifter.sv
//********************
// low-res engine, beam counters, line fetch and 2 bpp palette output
//********************
`timescale 1ns/100ps
`include "video_settings.svh"

module lores_shifter (
  input  logic              clk_128,
  input  logic              arst_n,
  input  video_pkg::vaddr_t base,
  input  video_pkg::rgb_t   pal0,
  input  video_pkg::rgb_t   pal1,
  input  video_pkg::rgb_t   pal2,
  input  video_pkg::rgb_t   pal3,
  output logic              req,
  output video_pkg::vaddr_t addr,
  input  logic              gnt,
  input  video_pkg::vword_t rdata,
  input  logic              rvalid,
  output logic              de,
  output logic              hs,
  output logic              vs,
  output video_pkg::rgb_t   rgb,
  output logic              line_odd
);
  import video_pkg::*;

  localparam hcount_t HACT   = hcount_t'(`LO_HACT);
  localparam hcount_t HTOT   = hcount_t'(`LO_HTOT);
  localparam vcount_t VACT   = vcount_t'(`LO_VACT);
  localparam vcount_t VTOT   = vcount_t'(`LO_VTOT);
  localparam hcount_t HS_ON  = hcount_t'(`LO_HACT + `HS_START);
  localparam hcount_t HS_OFF = hcount_t'(`LO_HACT + `HS_START + `HS_LEN);
  localparam vcount_t VS_OFF = vcount_t'(`LO_VACT + `VS_LINES);

  hcount_t      hcnt;
  vcount_t      vcnt;
  vcount_t      next_line;
  fetch_state_e fstate;
  logic         word_sel;  // which half of the line is being fetched
  vword_t       line_buf [2];
  logic [31:0]  pix_sr;  // 16 pixels, msb first
  pal_idx_t     pix_idx;
  rgb_t         pix_rgb;
  logic         line_end, next_active, active;

  assign line_end    = (hcnt == HTOT - 1'b1);
  assign next_line   = (vcnt == VTOT - 1'b1) ? '0 : vcnt + 1'b1;  // wraps to line 0
  assign next_active = (next_line < VACT);
  assign active      = (hcnt < HACT) && (vcnt < VACT);
  assign req         = (fstate == FS_REQ);

  always_ff @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      hcnt <= '0;
      vcnt <= '0;
    end else begin
      hcnt <= line_end ? '0 : hcnt + 1'b1;
      if (line_end) vcnt <= next_line;
    end
  end

  // fetch of the next line, starts at blank entry
  always_ff @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      fstate   <= FS_IDLE;
      word_sel <= 1'b0;
      addr     <= '0;
    end else begin
      case (fstate)
        FS_IDLE: if (hcnt == HACT && next_active) begin
          addr     <= base + vaddr_t'({next_line, 1'b0});  // 2 words per line
          word_sel <= 1'b0;
          fstate   <= FS_REQ;
        end
        FS_REQ: if (gnt) fstate <= FS_WAIT;
        FS_WAIT: if (rvalid) begin
          if (word_sel) begin
            fstate <= FS_DONE;
          end else begin
            word_sel <= 1'b1;
            addr     <= addr + 1'b1;
            fstate   <= FS_REQ;
          end
        end
        FS_DONE: if (line_end) fstate <= FS_IDLE;
        default: fstate <= FS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_128) begin
    if (fstate == FS_WAIT && rvalid) line_buf[word_sel] <= rdata;
    if (line_end && next_active) pix_sr <= {line_buf[0], line_buf[1]};  // swap at active start
    else if (active) pix_sr <= pix_sr << 2;
  end

  assign pix_idx = pix_sr[31:30];

  always_comb begin
    case (pix_idx)
      2'd0:    pix_rgb = pal0;
      2'd1:    pix_rgb = pal1;
      2'd2:    pix_rgb = pal2;
      default: pix_rgb = pal3;
    endcase
  end

  // one cycle behind the counters
  always_ff @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      de       <= 1'b0;
      hs       <= 1'b0;
      vs       <= 1'b0;
      rgb      <= '0;
      line_odd <= 1'b0;
    end else begin
      de       <= active;
      hs       <= (hcnt >= HS_ON) && (hcnt < HS_OFF);
      vs       <= (vcnt >= VACT) && (vcnt < VS_OFF);
      rgb      <= active ? pix_rgb : '0;  // black in blank
      line_odd <= vcnt[0];
    end
  end

endmodule

//--- logic/video_output.sv
//********************
// source select, sync delay and polarity, scanline dimming
//********************
`timescale 1ns/100ps

module video_output (
  input  logic                    clk_128,
  input  logic                    arst_n,
  input  video_pkg::vid_mode_e    mode,
  input  logic                    lo_de,
  input  logic                    lo_hs,
  input  logic                    lo_vs,
  input  video_pkg::rgb_t         lo_rgb,
  input  logic                    lo_odd,
  input  logic                    hi_de,
  input  logic                    hi_hs,
  input  logic                    hi_vs,
  input  video_pkg::rgb_t         hi_rgb,
  input  logic                    hi_odd,
  input  video_regs_pkg::adjust_t adjust,
  input  logic                    hs_pol,
  input  logic                    vs_pol,
  input  logic                    scanline_en,
  output logic                    de,
  output logic                    hs,
  output logic                    vs,
  output video_pkg::rgb_t         rgb
);
  import video_pkg::*;

  logic       sel_de, sel_hs, sel_vs, sel_odd;
  rgb_t       sel_rgb;
  rgb_t       dim_rgb;
  logic [7:0] hs_dly;  // tap 0 is one cycle late
  logic [7:0] vs_dly;

  always_comb begin
    if (mode == MODE_HIRES) begin
      sel_de  = hi_de;
      sel_hs  = hi_hs;
      sel_vs  = hi_vs;
      sel_rgb = hi_rgb;
      sel_odd = hi_odd;
    end else begin
      sel_de  = lo_de;
      sel_hs  = lo_hs;
      sel_vs  = lo_vs;
      sel_rgb = lo_rgb;
      sel_odd = lo_odd;
    end
  end

  // half intensity per channel
  assign dim_rgb = {1'b0, sel_rgb[11:9], 1'b0, sel_rgb[7:5], 1'b0, sel_rgb[3:1]};

  always_ff @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      de     <= 1'b0;
      rgb    <= '0;
      hs_dly <= '0;
      vs_dly <= '0;
      hs     <= 1'b0;
      vs     <= 1'b0;
    end else begin
      de     <= sel_de;
      rgb    <= (scanline_en && sel_odd) ? dim_rgb : sel_rgb;
      hs_dly <= {hs_dly[6:0], sel_hs};
      vs_dly <= {vs_dly[6:0], sel_vs};
      // adjust + 1 cycles behind de
      hs     <= hs_dly[adjust] ^ hs_pol;
      vs     <= vs_dly[adjust] ^ vs_pol;  // pol 0 means active high
    end
  end

endmodule

//--- logic/video_pkg.sv
//********************
// video format types, fetch fsm states and source modes
//********************
`include "video_settings.svh"

package video_pkg;

  typedef logic [`VID_AW-1:0] vaddr_t;  // word address into video memory
  typedef logic [`VID_DW-1:0] vword_t;  // one memory word

  // 4 bits per channel, r in the top nibble
  typedef logic [11:0] rgb_t;

  typedef logic [1:0] pal_idx_t;  // low-res palette index

  // beam position, wide enough for both frame formats
  typedef logic [5:0] hcount_t;
  typedef logic [5:0] vcount_t;

  // which engine drives the output
  typedef enum logic {
    MODE_LORES = 1'b0,
    MODE_HIRES = 1'b1
  } vid_mode_e;

  // line fetch, two words per line
  typedef enum logic [1:0] {
    FS_IDLE,  // waiting for blank entry
    FS_REQ,   // req held until gnt
    FS_WAIT,  // read in flight
    FS_DONE   // both words in, waiting for line swap
  } fetch_state_e;

endpackage

//--- logic/video_regs.sv
//********************
// apb slave, control bits, base addresses, sync adjust and palette
//********************
`timescale 1ns/100ps

module video_regs (
  input  logic                     clk_128,
  input  logic                     arst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [7:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output video_pkg::vid_mode_e     mode,
  output logic                     hs_pol,
  output logic                     vs_pol,
  output logic                     scanline_en,
  output logic                     hi_invert,
  output video_pkg::vaddr_t        lo_base,
  output video_pkg::vaddr_t        hi_base,
  output video_regs_pkg::adjust_t  adjust,
  output video_pkg::rgb_t          pal0,
  output video_pkg::rgb_t          pal1,
  output video_pkg::rgb_t          pal2,
  output video_pkg::rgb_t          pal3
);
  import video_pkg::*;
  import video_regs_pkg::*;

  logic wr_en;

  assign pready = 1'b1;  // no wait states
  assign wr_en  = psel && penable && pwrite;  // end of access phase

  always_ff @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      mode        <= MODE_LORES;
      hs_pol      <= 1'b0;
      vs_pol      <= 1'b0;
      scanline_en <= 1'b0;
      hi_invert   <= 1'b0;
      lo_base     <= '0;
      hi_base     <= '0;
      adjust      <= '0;
      pal0        <= '0;  // black palette out of reset
      pal1        <= '0;
      pal2        <= '0;
      pal3        <= '0;
    end else if (wr_en) begin
      case (paddr)
        RA_CTRL: begin
          mode        <= vid_mode_e'(pwdata[CTRL_MODE]);
          hs_pol      <= pwdata[CTRL_HS_POL];
          vs_pol      <= pwdata[CTRL_VS_POL];
          scanline_en <= pwdata[CTRL_SCANLINE];
          hi_invert   <= pwdata[CTRL_HI_INV];
        end
        RA_LO_BASE: lo_base <= pwdata[15:0];
        RA_HI_BASE: hi_base <= pwdata[15:0];
        RA_ADJ:     adjust  <= pwdata[2:0];
        RA_PAL0:    pal0    <= pwdata[11:0];
        RA_PAL1:    pal1    <= pwdata[11:0];
        RA_PAL2:    pal2    <= pwdata[11:0];
        RA_PAL3:    pal3    <= pwdata[11:0];
        default: ;  // unmapped, write dropped
      endcase
    end
  end

  // read mux, zero extended fields
  always_comb begin
    prdata = '0;
    case (paddr)
      RA_CTRL: begin
        prdata[CTRL_MODE]     = mode;
        prdata[CTRL_HS_POL]   = hs_pol;
        prdata[CTRL_VS_POL]   = vs_pol;
        prdata[CTRL_SCANLINE] = scanline_en;
        prdata[CTRL_HI_INV]   = hi_invert;
      end
      RA_LO_BASE: prdata[15:0] = lo_base;
      RA_HI_BASE: prdata[15:0] = hi_base;
      RA_ADJ:     prdata[2:0]  = adjust;
      RA_PAL0:    prdata[11:0] = pal0;
      RA_PAL1:    prdata[11:0] = pal1;
      RA_PAL2:    prdata[11:0] = pal2;
      RA_PAL3:    prdata[11:0] = pal3;
      default: ;
    endcase
  end

endmodule

//--- logic/video_regs_pkg.sv
//********************
// register map types and control field positions
//********************
`include "video_settings.svh"

package video_regs_pkg;

  typedef enum logic [7:0] {
    RA_CTRL    = `REG_CTRL,
    RA_LO_BASE = `REG_LO_BASE,
    RA_HI_BASE = `REG_HI_BASE,
    RA_ADJ     = `REG_ADJ,
    RA_PAL0    = `REG_PAL0,
    RA_PAL1    = `REG_PAL1,
    RA_PAL2    = `REG_PAL2,
    RA_PAL3    = `REG_PAL3
  } reg_addr_e;

  typedef logic [2:0] adjust_t;  // extra sync delay in cycles

  // bit positions inside the control word
  typedef enum int unsigned {
    CTRL_MODE     = 0,
    CTRL_HS_POL   = 1,
    CTRL_VS_POL   = 2,
    CTRL_SCANLINE = 3,
    CTRL_HI_INV   = 4
  } ctrl_bit_e;

endpackage

//--- logic/video_settings.svh
//********************
// frame timing, address widths and register map of the video block
//********************
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

`define VID_AW 16  // video word address width
`define VID_DW 16  // video memory word width

// low-res frame, pixels per line and lines per frame
`define LO_HACT 16
`define LO_HTOT 48
`define LO_VACT 4
`define LO_VTOT 6

// high-res frame
`define HI_HACT 32
`define HI_HTOT 48
`define HI_VACT 6
`define HI_VTOT 8

`define HS_START 4  // active end to hsync start, adjust 0
`define HS_LEN   6
`define VS_LINES 1

// apb register offsets
`define REG_CTRL    8'h00
`define REG_LO_BASE 8'h04
`define REG_HI_BASE 8'h08
`define REG_ADJ     8'h0C
`define REG_PAL0    8'h10
`define REG_PAL1    8'h14
`define REG_PAL2    8'h18
`define REG_PAL3    8'h1C

`endif

//--- logic/video_top.sv
//********************
// video block top, registers, two engines, arbiter and output stage
//********************
`timescale 1ns/100ps

module video_top (
  input  logic              clk_128,
  input  logic              arst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [7:0]        paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              mem_read,
  output video_pkg::vaddr_t mem_addr,
  input  video_pkg::vword_t mem_data,
  input  logic              mem_valid,
  output logic              de,
  output logic              hs,
  output logic              vs,
  output video_pkg::rgb_t   rgb
);
  import video_pkg::*;
  import video_regs_pkg::*;

  vid_mode_e mode;
  logic      hs_pol, vs_pol, scanline_en, hi_invert;
  vaddr_t    lo_base, hi_base;
  adjust_t   adjust;
  rgb_t      pal0, pal1, pal2, pal3;

  // engine to arbiter
  logic      lo_req, lo_gnt, lo_rvalid;
  logic      hi_req, hi_gnt, hi_rvalid;
  vaddr_t    lo_addr, hi_addr;
  vword_t    vm_rdata;

  // engine streams
  logic      lo_de, lo_hs, lo_vs, lo_odd;
  logic      hi_de, hi_hs, hi_vs, hi_odd;
  rgb_t      lo_rgb, hi_rgb;

  video_regs i_regs (
    .clk_128, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .mode, .hs_pol, .vs_pol, .scanline_en, .hi_invert, .lo_base, .hi_base,
    .adjust, .pal0, .pal1, .pal2, .pal3
  );

  lores_shifter i_lores (
    .clk_128, .arst_n, .base(lo_base), .pal0, .pal1, .pal2, .pal3,
    .req(lo_req), .addr(lo_addr), .gnt(lo_gnt), .rdata(vm_rdata), .rvalid(lo_rvalid),
    .de(lo_de), .hs(lo_hs), .vs(lo_vs), .rgb(lo_rgb), .line_odd(lo_odd)
  );

  hires_shifter i_hires (
    .clk_128, .arst_n, .base(hi_base), .invert(hi_invert),
    .req(hi_req), .addr(hi_addr), .gnt(hi_gnt), .rdata(vm_rdata), .rvalid(hi_rvalid),
    .de(hi_de), .hs(hi_hs), .vs(hi_vs), .rgb(hi_rgb), .line_odd(hi_odd)
  );

  // port 0 is lores
  vmem_arbiter i_arb (
    .clk_128, .arst_n,
    .req0(lo_req), .addr0(lo_addr), .gnt0(lo_gnt), .rvalid0(lo_rvalid),
    .req1(hi_req), .addr1(hi_addr), .gnt1(hi_gnt), .rvalid1(hi_rvalid),
    .rdata(vm_rdata), .mem_read, .mem_addr, .mem_data, .mem_valid
  );

  video_output i_out (
    .clk_128, .arst_n, .mode,
    .lo_de, .lo_hs, .lo_vs, .lo_rgb, .lo_odd,
    .hi_de, .hi_hs, .hi_vs, .hi_rgb, .hi_odd,
    .adjust, .hs_pol, .vs_pol, .scanline_en,
    .de, .hs, .vs, .rgb
  );

endmodule

//--- logic/vmem_arbiter.sv
//********************
// round-robin share of the video memory read port
//********************
`timescale 1ns/100ps

module vmem_arbiter (
  input  logic              clk_128,
  input  logic              arst_n,
  input  logic              req0,
  input  video_pkg::vaddr_t addr0,
  output logic              gnt0,
  output logic              rvalid0,
  input  logic              req1,
  input  video_pkg::vaddr_t addr1,
  output logic              gnt1,
  output logic              rvalid1,
  output video_pkg::vword_t rdata,
  output logic              mem_read,
  output video_pkg::vaddr_t mem_addr,
  input  video_pkg::vword_t mem_data,
  input  logic              mem_valid
);

  logic pending;   // read in flight
  logic owner;     // requester of that read
  logic last_win;  // winner of the last grant
  logic pick1;

  // tie goes to whoever did not win last
  assign pick1 = req1 && (!req0 || !last_win);

  assign gnt0 = !pending && req0 && !pick1;
  assign gnt1 = !pending && pick1;

  assign rvalid0 = pending && mem_valid && !owner;
  assign rvalid1 = pending && mem_valid && owner;
  assign rdata   = mem_data;  // shared, qualified by rvalid

  always_ff @(posedge clk_128 or negedge arst_n) begin
    if (!arst_n) begin
      mem_read <= 1'b0;
      mem_addr <= '0;
      pending  <= 1'b0;
      owner    <= 1'b0;
      last_win <= 1'b1;  // lores takes the first tie
    end else begin
      mem_read <= gnt0 || gnt1;  // single cycle pulse
      if (gnt0 || gnt1) begin
        mem_addr <= pick1 ? addr1 : addr0;
        pending  <= 1'b1;
        owner    <= pick1;
        last_win <= pick1;
      end else if (mem_valid) begin
        pending  <= 1'b0;
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the video block testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_video -o tb_video \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_video > sim.log 2>&1 || echo "simulator returned a non-zero status"

cat sim.log
grep -q "Simulation finished: PASS" sim.log \
  && echo "run_sim: passed" \
  || { echo "run_sim: failed, see sim.log"; exit 1; }

//--- vlog.f
+incdir+logic
logic/video_pkg.sv
logic/video_regs_pkg.sv
logic/video_regs.sv
logic/lores_shifter.sv
logic/hires_shifter.sv
logic/vmem_arbiter.sv
logic/video_output.sv
logic/video_top.sv
bench/video_checker.sv
bench/tb_video.sv
